// ==== crc_pkg.sv ====
// CRC-32 lane constants
`default_nettype none

package crc_pkg;

    // crc-32/mpeg-2, msb first, no reflection, no final xor
    localparam logic [31:0] crc_poly = 32'h04c1_1db7;

    // value after reset or clear
    localparam logic [31:0] crc_init = 32'hffff_ffff;

    // lanes are selected by address bits 5..4
    localparam int num_lanes = 4;
    localparam int lane_bits = 2;

    typedef logic [lane_bits-1:0] lane_idx_t;

endpackage

`default_nettype wire

// ==== regs_pkg.sv ====
// AXI4-Lite and register map types
`default_nettype none

package regs_pkg;

    localparam int addr_bits = 6;

    // register index, address bits 3..2
    localparam logic [1:0] reg_data = 2'd0;
    localparam logic [1:0] reg_ctrl = 2'd1;
    localparam logic [1:0] reg_crc  = 2'd2;

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    typedef struct packed {
        logic [addr_bits-1:0] addr;
    } axil_aw_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
    } axil_w_t;

    typedef struct packed {
        logic [addr_bits-1:0] addr;
    } axil_ar_t;

    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
    } axil_r_t;

    // one cycle of work for one lane
    typedef struct packed {
        logic        push;
        logic        clear;
        logic [31:0] data;
    } lane_cmd_t;

    typedef struct packed {
        logic [31:0] crc;
        logic [31:0] count;
    } lane_stat_t;

endpackage

`default_nettype wire

// ==== crc_lane.sv ====
// CRC-32 lane engine
`timescale 1ns/10ps
`default_nettype none

module crc_lane (
    input  logic                 clock,
    input  logic                 rst_n,
    input  regs_pkg::lane_cmd_t  cmd,
    output regs_pkg::lane_stat_t stat
);

    logic [31:0] crc_q;
    logic [31:0] count_q;
    logic [31:0] crc_next;

    // all 32 data bits shifted in, msb first
    function automatic logic [31:0] crc_word(input logic [31:0] crc, input logic [31:0] data);
        logic [31:0] c;
        logic        fb;
        c = crc;
        for (int i = 31; i >= 0; i--) begin
            fb = c[31] ^ data[i];
            c  = {c[30:0], 1'b0};
            if (fb) begin
                c = c ^ crc_pkg::crc_poly;
            end
        end
        return c;
    endfunction

    always_comb begin
        crc_next = crc_word(crc_q, cmd.data);
    end

    // clear takes priority over push
    always_ff @(posedge clock) begin
        if (!rst_n || cmd.clear) begin
            crc_q   <= crc_pkg::crc_init;
            count_q <= '0;
        end else if (cmd.push) begin
            crc_q   <= crc_next;
            count_q <= count_q + 32'd1;
        end
    end

    assign stat.crc   = crc_q;
    assign stat.count = count_q;

endmodule

`default_nettype wire

// ==== crc_dispatch.sv ====
// AXI4-Lite write side dispatcher
`timescale 1ns/10ps
`default_nettype none

module crc_dispatch (
    input  logic                clock,
    input  logic                rst_n,
    input  logic                awvalid,
    output logic                awready,
    input  regs_pkg::axil_aw_t  aw,
    input  logic                wvalid,
    output logic                wready,
    input  regs_pkg::axil_w_t   w,
    output logic                bvalid,
    input  logic                bready,
    output logic [1:0]          bresp,
    output regs_pkg::lane_cmd_t lane_cmd [crc_pkg::num_lanes]
);

    crc_pkg::lane_idx_t            lane;
    logic [1:0]                    reg_idx;
    logic                          accept;
    logic                          full_strb;
    logic                          wr_push;
    logic                          wr_clear;
    logic                          wr_err;
    logic [crc_pkg::num_lanes-1:0] push_d;
    logic [crc_pkg::num_lanes-1:0] clear_d;
    logic [crc_pkg::num_lanes-1:0] push_q;
    logic [crc_pkg::num_lanes-1:0] clear_q;
    logic [31:0]                   data_q;

    // aw and w taken together, one write in flight
    assign accept  = awvalid & wvalid & ~bvalid;
    assign awready = accept;
    assign wready  = accept;

    assign lane      = aw.addr[5:4];
    assign reg_idx   = aw.addr[3:2];
    assign full_strb = &w.strb;

    always_comb begin
        wr_push  = 1'b0;
        wr_clear = 1'b0;
        wr_err   = 1'b0;
        case (reg_idx)
            regs_pkg::reg_data: begin
                wr_push = full_strb;
                wr_err  = ~full_strb;
            end
            regs_pkg::reg_ctrl: begin
                wr_clear = full_strb & w.data[0];
                wr_err   = ~full_strb;
            end
            // crc is read only, index 3 unmapped
            default: wr_err = 1'b1;
        endcase
    end

    always_comb begin
        for (int i = 0; i < crc_pkg::num_lanes; i++) begin
            push_d[i]  = accept & wr_push & (lane == crc_pkg::lane_idx_t'(i));
            clear_d[i] = accept & wr_clear & (lane == crc_pkg::lane_idx_t'(i));
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            push_q  <= '0;
            clear_q <= '0;
            bvalid  <= 1'b0;
        end else begin
            push_q  <= push_d;
            clear_q <= clear_d;
            if (accept) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            data_q <= w.data;
            bresp  <= wr_err ? regs_pkg::resp_slverr : regs_pkg::resp_okay;
        end
    end

    // data word shared, strobes per lane
    always_comb begin
        for (int i = 0; i < crc_pkg::num_lanes; i++) begin
            lane_cmd[i].push  = push_q[i];
            lane_cmd[i].clear = clear_q[i];
            lane_cmd[i].data  = data_q;
        end
    end

endmodule

`default_nettype wire

// ==== crc_collect.sv ====
// AXI4-Lite read side collector
`timescale 1ns/10ps
`default_nettype none

module crc_collect (
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 arvalid,
    output logic                 arready,
    input  regs_pkg::axil_ar_t   ar,
    output logic                 rvalid,
    input  logic                 rready,
    output regs_pkg::axil_r_t    r,
    input  regs_pkg::lane_stat_t lane_stat [crc_pkg::num_lanes]
);

    crc_pkg::lane_idx_t   lane;
    logic [1:0]           reg_idx;
    logic                 accept;
    regs_pkg::lane_stat_t sel;
    regs_pkg::axil_r_t    r_d;

    // one read outstanding at a time
    assign accept  = arvalid & ~rvalid;
    assign arready = accept;

    assign lane    = ar.addr[5:4];
    assign reg_idx = ar.addr[3:2];
    assign sel     = lane_stat[lane];

    always_comb begin
        r_d.data = '0;
        r_d.resp = regs_pkg::resp_okay;
        case (reg_idx)
            // data is write only
            regs_pkg::reg_data: r_d.data = '0;
            regs_pkg::reg_ctrl: r_d.data = sel.count;
            regs_pkg::reg_crc:  r_d.data = sel.crc;
            default:            r_d.resp = regs_pkg::resp_slverr;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            rvalid <= 1'b0;
        end else if (accept) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    // held until rready since accept is blocked meanwhile
    always_ff @(posedge clock) begin
        if (accept) begin
            r <= r_d;
        end
    end

endmodule

`default_nettype wire

// ==== crc_accel_top.sv ====
// four lane CRC-32 accelerator
`timescale 1ns/10ps
`default_nettype none

module crc_accel_top (
    input  logic               clock,
    input  logic               rst_n,
    input  logic               awvalid,
    output logic               awready,
    input  regs_pkg::axil_aw_t aw,
    input  logic               wvalid,
    output logic               wready,
    input  regs_pkg::axil_w_t  w,
    output logic               bvalid,
    input  logic               bready,
    output logic [1:0]         bresp,
    input  logic               arvalid,
    output logic               arready,
    input  regs_pkg::axil_ar_t ar,
    output logic               rvalid,
    input  logic               rready,
    output regs_pkg::axil_r_t  r
);

    regs_pkg::lane_cmd_t  lane_cmd  [crc_pkg::num_lanes];
    regs_pkg::lane_stat_t lane_stat [crc_pkg::num_lanes];

    crc_dispatch dispatch_i (
        .clock    (clock),
        .rst_n    (rst_n),
        .awvalid  (awvalid),
        .awready  (awready),
        .aw       (aw),
        .wvalid   (wvalid),
        .wready   (wready),
        .w        (w),
        .bvalid   (bvalid),
        .bready   (bready),
        .bresp    (bresp),
        .lane_cmd (lane_cmd)
    );

    for (genvar i = 0; i < crc_pkg::num_lanes; i++) begin : lane_g
        crc_lane lane_i (
            .clock (clock),
            .rst_n (rst_n),
            .cmd   (lane_cmd[i]),
            .stat  (lane_stat[i])
        );
    end

    crc_collect collect_i (
        .clock     (clock),
        .rst_n     (rst_n),
        .arvalid   (arvalid),
        .arready   (arready),
        .ar        (ar),
        .rvalid    (rvalid),
        .rready    (rready),
        .r         (r),
        .lane_stat (lane_stat)
    );

endmodule

`default_nettype wire

// ==== tb_crc_accel.sv ====
// CRC accelerator testbench
`timescale 1ns/10ps
`default_nettype none

module tb_crc_accel;

    localparam int period = 100;
    localparam int wait_limit = 20;
    localparam logic [31:0] poly = 32'h04c1_1db7;

    logic               clock;
    logic               rst_n;
    logic               awvalid;
    logic               awready;
    regs_pkg::axil_aw_t aw;
    logic               wvalid;
    logic               wready;
    regs_pkg::axil_w_t  w;
    logic               bvalid;
    logic               bready;
    logic [1:0]         bresp;
    logic               arvalid;
    logic               arready;
    regs_pkg::axil_ar_t ar;
    logic               rvalid;
    logic               rready;
    regs_pkg::axil_r_t  r;

    logic [31:0] model_crc   [4];
    logic [31:0] model_count [4];
    integer      seed;
    int          check_count;
    int          error_count;
    int          timeout_count;

    crc_accel_top dut_i (
        .clock   (clock),
        .rst_n   (rst_n),
        .awvalid (awvalid),
        .awready (awready),
        .aw      (aw),
        .wvalid  (wvalid),
        .wready  (wready),
        .w       (w),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .ar      (ar),
        .rvalid  (rvalid),
        .rready  (rready),
        .r       (r)
    );

    initial begin
        clock = 1'b0;
        forever #(period / 2) clock = ~clock;
    end

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        check_count++;
        assert (act === exp) else begin
            error_count++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic report_timeout(input string what);
        timeout_count++;
        $display("timeout: %s", what);
    endtask

    // msb-first, non-reflected, one data bit per step
    function automatic logic [31:0] crc_step_model(input logic [31:0] crc, input logic [31:0] word);
        logic [31:0] acc;
        logic        top;
        acc = crc;
        for (int b = 0; b < 32; b++) begin
            top = acc[31] ^ word[31 - b];
            acc = acc << 1;
            if (top) begin
                acc = acc ^ poly;
            end
        end
        return acc;
    endfunction

    function automatic logic [5:0] make_addr(input int lane, input logic [1:0] reg_idx);
        return {lane[1:0], reg_idx, 2'b00};
    endfunction

    task automatic model_push(input int lane, input logic [31:0] word);
        model_crc[lane] = crc_step_model(model_crc[lane], word);
        model_count[lane]++;
    endtask

    task automatic axil_write(input string name, input logic [5:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, input int hold, output logic [1:0] resp);
        int waited;
        waited = 0;
        resp = 2'b11;
        @(negedge clock);
        awvalid = 1'b1;
        aw.addr = addr;
        wvalid  = 1'b1;
        w.data  = data;
        w.strb  = strb;
        #1;
        while (!(awready && wready)) begin
            if (waited == wait_limit) begin
                report_timeout({name, ": write address and data were never accepted"});
                awvalid = 1'b0;
                wvalid  = 1'b0;
                return;
            end
            waited++;
            @(negedge clock);
            #1;
        end
        // accepted at the coming posedge
        @(negedge clock);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        waited  = 0;
        while (!bvalid) begin
            if (waited == wait_limit) begin
                report_timeout({name, ": write response never arrived"});
                return;
            end
            waited++;
            @(negedge clock);
        end
        resp = bresp;
        if (hold > 0) begin
            // a second write with another payload must stall meanwhile
            awvalid = 1'b1;
            aw.addr = ~addr;
            wvalid  = 1'b1;
            w.strb  = ~strb;
        end
        for (int k = 0; k < hold; k++) begin
            @(negedge clock);
            check_value({name, " bvalid held"}, 32'd1, {31'd0, bvalid});
            check_value({name, " bresp held"}, 32'(resp), 32'(bresp));
            check_value({name, " awready stalled"}, 32'd0, {31'd0, awready});
            check_value({name, " wready stalled"}, 32'd0, {31'd0, wready});
        end
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        @(negedge clock);
        bready = 1'b0;
    endtask

    task automatic axil_read(input string name, input logic [5:0] addr, input int hold,
                             output logic [31:0] data, output logic [1:0] resp);
        int waited;
        waited = 0;
        data = '0;
        resp = 2'b11;
        @(negedge clock);
        arvalid = 1'b1;
        ar.addr = addr;
        #1;
        while (!arready) begin
            if (waited == wait_limit) begin
                report_timeout({name, ": read address was never accepted"});
                arvalid = 1'b0;
                return;
            end
            waited++;
            @(negedge clock);
            #1;
        end
        @(negedge clock);
        arvalid = 1'b0;
        waited  = 0;
        while (!rvalid) begin
            if (waited == wait_limit) begin
                report_timeout({name, ": read data never arrived"});
                return;
            end
            waited++;
            @(negedge clock);
        end
        data = r.data;
        resp = r.resp;
        if (hold > 0) begin
            // a second read of another register must stall meanwhile
            arvalid = 1'b1;
            ar.addr = ~addr;
        end
        for (int k = 0; k < hold; k++) begin
            @(negedge clock);
            check_value({name, " rvalid held"}, 32'd1, {31'd0, rvalid});
            check_value({name, " rdata held"}, data, r.data);
            check_value({name, " rresp held"}, 32'(resp), 32'(r.resp));
            check_value({name, " arready stalled"}, 32'd0, {31'd0, arready});
        end
        arvalid = 1'b0;
        rready  = 1'b1;
        @(negedge clock);
        rready = 1'b0;
    endtask

    task automatic verify_lane(input string name, input int lane);
        logic [31:0] data;
        logic [1:0]  resp;
        axil_read(name, make_addr(lane, regs_pkg::reg_crc), 0, data, resp);
        check_value({name, " crc"}, model_crc[lane], data);
        check_value({name, " crc resp"}, 32'(regs_pkg::resp_okay), 32'(resp));
        axil_read(name, make_addr(lane, regs_pkg::reg_ctrl), 0, data, resp);
        check_value({name, " count"}, model_count[lane], data);
        check_value({name, " count resp"}, 32'(regs_pkg::resp_okay), 32'(resp));
    endtask

    task automatic reset_state();
        for (int l = 0; l < 4; l++) begin
            verify_lane("reset_state", l);
        end
    endtask

    task automatic single_word();
        logic [1:0] resp;
        axil_write("single_word", make_addr(0, regs_pkg::reg_data), 32'h3132_3334, 4'hf, 0, resp);
        check_value("single_word resp", 32'(regs_pkg::resp_okay), 32'(resp));
        model_push(0, 32'h3132_3334);
        verify_lane("single_word", 0);
    endtask

    task automatic lane_isolation();
        logic [31:0] rnd;
        logic [31:0] word;
        logic [1:0]  resp;
        int          lane;
        for (int n = 0; n < 24; n++) begin
            rnd  = $random(seed);
            word = $random(seed);
            // first four words touch every lane once
            lane = (n < 4) ? n : int'(rnd[1:0]);
            axil_write("lane_isolation", make_addr(lane, regs_pkg::reg_data), word, 4'hf, 0, resp);
            check_value("lane_isolation resp", 32'(regs_pkg::resp_okay), 32'(resp));
            model_push(lane, word);
        end
        for (int l = 0; l < 4; l++) begin
            verify_lane("lane_isolation", l);
        end
    endtask

    task automatic clear_lane();
        logic [1:0] resp;
        axil_write("clear", make_addr(2, regs_pkg::reg_ctrl), 32'h0000_0000, 4'hf, 0, resp);
        check_value("clear nop resp", 32'(regs_pkg::resp_okay), 32'(resp));
        verify_lane("clear nop", 2);
        axil_write("clear", make_addr(2, regs_pkg::reg_ctrl), 32'h0000_0001, 4'hf, 0, resp);
        check_value("clear resp", 32'(regs_pkg::resp_okay), 32'(resp));
        model_crc[2]   = 32'hffff_ffff;
        model_count[2] = 32'd0;
        for (int l = 0; l < 4; l++) begin
            verify_lane("clear", l);
        end
    endtask

    task automatic error_responses();
        logic [31:0] data;
        logic [1:0]  resp;
        axil_write("errors", make_addr(1, regs_pkg::reg_data), 32'hdead_beef, 4'b0111, 0, resp);
        check_value("errors partial strobe resp", 32'(regs_pkg::resp_slverr), 32'(resp));
        verify_lane("errors partial strobe", 1);
        axil_write("errors", make_addr(1, regs_pkg::reg_crc), 32'h1234_5678, 4'hf, 0, resp);
        check_value("errors crc write resp", 32'(regs_pkg::resp_slverr), 32'(resp));
        verify_lane("errors crc write", 1);
        axil_read("errors", make_addr(0, 2'd3), 0, data, resp);
        check_value("errors index 3 resp", 32'(regs_pkg::resp_slverr), 32'(resp));
        check_value("errors index 3 data", 32'd0, data);
        axil_read("errors", make_addr(0, regs_pkg::reg_data), 0, data, resp);
        check_value("errors data read", 32'd0, data);
    endtask

    task automatic back_pressure();
        logic [31:0] word;
        logic [31:0] data;
        logic [1:0]  resp;
        word = $random(seed);
        axil_write("back_pressure", make_addr(3, regs_pkg::reg_data), word, 4'hf, 5, resp);
        check_value("back_pressure write resp", 32'(regs_pkg::resp_okay), 32'(resp));
        model_push(3, word);
        axil_read("back_pressure", make_addr(3, regs_pkg::reg_crc), 4, data, resp);
        check_value("back_pressure crc", model_crc[3], data);
        check_value("back_pressure crc resp", 32'(regs_pkg::resp_okay), 32'(resp));
        axil_read("back_pressure", make_addr(3, regs_pkg::reg_ctrl), 3, data, resp);
        check_value("back_pressure count", model_count[3], data);
        check_value("back_pressure count resp", 32'(regs_pkg::resp_okay), 32'(resp));
    endtask

    initial begin
        rst_n   = 1'b0;
        awvalid = 1'b0;
        aw      = '0;
        wvalid  = 1'b0;
        w       = '0;
        bready  = 1'b0;
        arvalid = 1'b0;
        ar      = '0;
        rready  = 1'b0;
        seed          = 32'hec78_56c9;
        check_count   = 0;
        error_count   = 0;
        timeout_count = 0;
        for (int l = 0; l < 4; l++) begin
            model_crc[l]   = 32'hffff_ffff;
            model_count[l] = 32'd0;
        end
        repeat (3) @(negedge clock);
        rst_n = 1'b1;

        reset_state();
        single_word();
        lane_isolation();
        clear_lane();
        error_responses();
        back_pressure();

        $display("checks: %0d, errors: %0d, timeouts: %0d", check_count, error_count,
                 timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
crc_pkg.sv
regs_pkg.sv
crc_lane.sv
crc_dispatch.sv
crc_collect.sv
crc_accel_top.sv
tb_crc_accel.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_crc_accel -f tb.f -o sim_crc_accel

out=$(./obj_dir/sim_crc_accel)
echo "$out"

# exits non-zero when the pass line is missing
echo "$out" | grep -q "TEST RESULT: PASS"
